// File: logic/cache_geom_pkg.sv
/*
 * data cache geometry
 * sizes, address field widths and the line storage types shared by
 * the array, lookup, walker and controller
 */
package cache_geom_pkg;

    // 1 KiB of data, 2 ways of 2-word blocks
    localparam int N_WAYS      = 2;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = 64;

    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS   = 32 - SET_BITS - BLOCK_BITS - 2;

    // everything from here up goes straight to memory
    localparam logic [31:0] NONCACHE_START = 32'h8000_0000;

    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [SET_BITS-1:0]        set_idx_t;
    typedef logic [BLOCK_BITS-1:0]      word_sel_t;
    typedef logic [$clog2(N_WAYS)-1:0]  way_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    typedef logic [BLOCK_WORDS-1:0][31:0] line_data_t;

    // one write into the line store, mask bit set means the data bit is written
    typedef struct packed {
        logic       en;
        set_idx_t   set;
        way_t       way;
        line_meta_t meta;
        line_data_t data;
        line_data_t mask;
    } line_write_t;

endpackage

// File: logic/cache_bus_pkg.sv
/*
 * core and memory port definitions
 * wait-based handshake on both sides, busy toward the core and
 * a wait flag back from memory
 */
package cache_bus_pkg;

    localparam int WORD_BITS = 32;
    localparam int ADDR_BITS = 32;
    localparam int BE_BITS   = WORD_BITS / 8;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [BE_BITS-1:0]   byte_en_t;

    // a full block as it moves over the memory port
    typedef word_t [cache_geom_pkg::BLOCK_WORDS-1:0] mem_block_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } core_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } core_rsp_t;

    // uncached accesses use word slot 0 of wdata
    typedef struct packed {
        logic       ren;
        logic       wen;
        addr_t      addr;
        mem_block_t wdata;
        byte_en_t   byte_en;
    } mem_req_t;

    typedef struct packed {
        logic       dwait;
        mem_block_t rdata;
    } mem_rsp_t;

endpackage

// File: logic/cache_line_store.sv
/*
 * tag and data arrays for both ways
 * reads the selected set without a clock, writes one way per cycle
 * under a bit mask
 */
`timescale 1ns/1ps

module cache_line_store (
    input  logic                                                  CLK,
    input  logic                                                  nRST,
    input  cache_geom_pkg::set_idx_t                              sel_set,
    input  cache_geom_pkg::line_write_t                           wr,
    output cache_geom_pkg::line_meta_t [cache_geom_pkg::N_WAYS-1:0] meta,
    output cache_geom_pkg::line_data_t [cache_geom_pkg::N_WAYS-1:0] data
);
    import cache_geom_pkg::*;

    logic [N_SETS-1:0][N_WAYS-1:0] valid_q;
    logic                          dirty_q [N_SETS][N_WAYS];
    tag_t                          tag_q   [N_SETS][N_WAYS];
    line_data_t                    data_q  [N_SETS][N_WAYS];

    // valid bits are the only state cleared by reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (wr.en) begin
            valid_q[wr.set][wr.way] <= wr.meta.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr.en) begin
            dirty_q[wr.set][wr.way] <= wr.meta.dirty;
            tag_q[wr.set][wr.way]   <= wr.meta.tag;
            // merge under the mask
            data_q[wr.set][wr.way]  <= (data_q[wr.set][wr.way] & ~wr.mask)
                                     | (wr.data & wr.mask);
        end
    end

    // asynchronous read of both ways
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            meta[w].valid = valid_q[sel_set][w];
            meta[w].dirty = dirty_q[sel_set][w];
            meta[w].tag   = tag_q[sel_set][w];
            data[w]       = data_q[sel_set][w];
        end
    end

endmodule

// File: logic/way_lookup.sv
/*
 * tag compare and NRU replacement
 * finds the hit way of the selected set and keeps one last-used
 * bit per set to pick the victim
 */
`timescale 1ns/1ps

module way_lookup (
    input  logic                                                  CLK,
    input  logic                                                  nRST,
    input  cache_geom_pkg::set_idx_t                              set,
    input  cache_geom_pkg::tag_t                                  tag,
    input  cache_geom_pkg::line_meta_t [cache_geom_pkg::N_WAYS-1:0] meta,
    input  logic                                                  touch,
    output logic                                                  hit,
    output cache_geom_pkg::way_t                                  hit_way,
    output cache_geom_pkg::way_t                                  victim_way
);
    import cache_geom_pkg::*;

    way_t [N_SETS-1:0] last_used_q;

    // compare against the valid ways only
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (meta[w].valid && meta[w].tag == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // two ways, so the victim is simply the other one
    assign victim_way = ~last_used_q[set];

    // on a fill there is no hit yet and the filled way is the victim
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used_q <= '0;
        end else if (touch) begin
            last_used_q[set] <= hit ? hit_way : victim_way;
        end
    end

endmodule

// File: logic/flush_walker.sv
/*
 * set/way walker
 * steps through every way of every set for the reset invalidation
 * and for a flush, then holds done
 */
`timescale 1ns/1ps

module flush_walker (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     start,
    input  logic                     step,
    output cache_geom_pkg::set_idx_t set,
    output cache_geom_pkg::way_t     way,
    output logic                     done
);
    import cache_geom_pkg::*;

    // way in the low bits so both ways of a set come back to back
    typedef struct packed {
        set_idx_t set;
        way_t     way;
    } walk_pos_t;

    walk_pos_t pos_q;
    logic      done_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pos_q  <= '0;
            done_q <= 1'b0;
        end else if (start) begin
            pos_q  <= '0;
            done_q <= 1'b0;
        end else if (step && !done_q) begin
            if (pos_q == '1) begin
                done_q <= 1'b1;
            end
            // wraps back to set 0 way 0 after the last position
            pos_q <= walk_pos_t'(pos_q + 1'b1);
        end
    end

    assign set  = pos_q.set;
    assign way  = pos_q.way;
    assign done = done_q;

endmodule

// File: logic/dcache_controller.sv
/*
 * data cache controller
 * FSM for hits, block fills with dirty writeback, uncached accesses,
 * invalidation after reset and flush
 */
`timescale 1ns/1ps

module dcache_controller (
    input  logic                                                  CLK,
    input  logic                                                  nRST,
    input  cache_bus_pkg::core_req_t                              core_req,
    output cache_bus_pkg::core_rsp_t                              core_rsp,
    output cache_bus_pkg::mem_req_t                               mem_req,
    input  cache_bus_pkg::mem_rsp_t                               mem_rsp,
    input  logic                                                  flush,
    input  logic                                                  hit,
    input  cache_geom_pkg::way_t                                  hit_way,
    input  cache_geom_pkg::way_t                                  victim_way,
    input  cache_geom_pkg::line_meta_t [cache_geom_pkg::N_WAYS-1:0] meta,
    input  cache_geom_pkg::line_data_t [cache_geom_pkg::N_WAYS-1:0] data,
    input  cache_geom_pkg::set_idx_t                              walk_set,
    input  cache_geom_pkg::way_t                                  walk_way,
    input  logic                                                  walk_done,
    output cache_geom_pkg::set_idx_t                              sel_set,
    output cache_geom_pkg::line_write_t                           wr,
    output logic                                                  touch,
    output logic                                                  walk_start,
    output logic                                                  walk_step,
    output logic                                                  flush_done,
    output logic                                                  cache_miss
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [2:0] {
        INIT,
        READY,
        WRITEBACK,
        FETCH,
        UNCACHED,
        FLUSHING
    } state_t;

    typedef struct packed {
        tag_t       tag;
        set_idx_t   set;
        word_sel_t  word;
        logic [1:0] byte_off;
    } addr_fields_t;

    state_t       state_q, state_d;
    addr_fields_t req_f, miss_q;
    logic         flush_pend_q;
    logic         req_valid, req_uncached;
    byte_en_t     be_eff;
    word_t        wmask;
    line_meta_t   victim_meta, walk_meta;
    line_data_t   fill_data;

    // expand byte enables into a bit mask
    function automatic word_t lane_mask(byte_en_t be);
        word_t m;
        for (int i = 0; i < BE_BITS; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    assign req_f        = addr_fields_t'(core_req.addr);
    assign req_valid    = core_req.ren || core_req.wen;
    assign req_uncached = core_req.addr >= NONCACHE_START;
    assign victim_meta  = meta[victim_way];
    assign walk_meta    = meta[walk_way];
    assign wmask        = lane_mask(be_eff);

    // single bytes and aligned halves as given, anything else is a full word
    always_comb begin
        case (core_req.byte_en)
            4'b0001, 4'b0010, 4'b0100, 4'b1000,
            4'b0011, 4'b1100: be_eff = core_req.byte_en;
            default:          be_eff = '1;
        endcase
    end

    // fill block with the store merged in on a write miss
    always_comb begin
        fill_data = mem_rsp.rdata;
        if (core_req.wen) begin
            fill_data[miss_q.word] = (mem_rsp.rdata[miss_q.word] & ~wmask)
                                   | (core_req.wdata & wmask);
        end
    end

    always_comb begin
        state_d       = state_q;
        core_rsp      = '0;
        core_rsp.busy = 1'b1;
        mem_req       = '0;
        wr            = '0;
        sel_set       = req_f.set;
        touch         = 1'b0;
        walk_start    = 1'b0;
        walk_step     = 1'b0;
        flush_done    = 1'b0;
        cache_miss    = 1'b0;

        case (state_q)
            INIT: begin
                sel_set = walk_set;
                if (walk_done) begin
                    state_d = READY;
                end else begin
                    // meta of zero invalidates, data untouched
                    wr.en     = 1'b1;
                    wr.set    = walk_set;
                    wr.way    = walk_way;
                    walk_step = 1'b1;
                end
            end
            READY: begin
                if (flush || flush_pend_q) begin
                    walk_start = 1'b1;
                    state_d    = FLUSHING;
                end else if (req_valid && req_uncached) begin
                    state_d = UNCACHED;
                end else if (req_valid && hit) begin
                    core_rsp.busy = 1'b0;
                    touch         = 1'b1;
                    if (core_req.ren) begin
                        core_rsp.rdata = data[hit_way][req_f.word];
                    end
                    if (core_req.wen) begin
                        wr.en               = 1'b1;
                        wr.set              = req_f.set;
                        wr.way              = hit_way;
                        wr.meta             = '{valid: 1'b1, dirty: 1'b1, tag: req_f.tag};
                        wr.data[req_f.word] = core_req.wdata;
                        wr.mask[req_f.word] = wmask;
                    end
                end else if (req_valid) begin
                    state_d = (victim_meta.valid && victim_meta.dirty) ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                sel_set         = miss_q.set;
                mem_req.wen     = 1'b1;
                mem_req.addr    = {victim_meta.tag, miss_q.set, word_sel_t'(0), 2'b00};
                mem_req.wdata   = data[victim_way];
                mem_req.byte_en = '1;
                if (!mem_rsp.dwait) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                sel_set         = miss_q.set;
                mem_req.ren     = 1'b1;
                mem_req.addr    = {miss_q.tag, miss_q.set, word_sel_t'(0), 2'b00};
                mem_req.byte_en = '1;
                if (!mem_rsp.dwait) begin
                    wr.en      = 1'b1;
                    wr.set     = miss_q.set;
                    wr.way     = victim_way;
                    wr.meta    = '{valid: 1'b1, dirty: core_req.wen, tag: miss_q.tag};
                    wr.data    = fill_data;
                    wr.mask    = '1;
                    touch      = 1'b1;
                    cache_miss = 1'b1;
                    state_d    = READY;
                end
            end
            UNCACHED: begin
                mem_req.ren      = core_req.ren;
                mem_req.wen      = core_req.wen;
                mem_req.addr     = {core_req.addr[31:2], 2'b00};
                mem_req.byte_en  = be_eff;
                mem_req.wdata[0] = core_req.wdata;
                if (!mem_rsp.dwait) begin
                    core_rsp.busy  = 1'b0;
                    core_rsp.rdata = core_req.ren ? mem_rsp.rdata[0] : '0;
                    state_d        = READY;
                end
            end
            FLUSHING: begin
                sel_set = walk_set;
                if (walk_done) begin
                    flush_done = 1'b1;
                    state_d    = READY;
                end else begin
                    if (walk_meta.valid && walk_meta.dirty) begin
                        mem_req.wen     = 1'b1;
                        mem_req.addr    = {walk_meta.tag, walk_set, word_sel_t'(0), 2'b00};
                        mem_req.wdata   = data[walk_way];
                        mem_req.byte_en = '1;
                    end
                    // clean lines drop at once, dirty ones after their beat
                    if (!mem_req.wen || !mem_rsp.dwait) begin
                        wr.en     = 1'b1;
                        wr.set    = walk_set;
                        wr.way    = walk_way;
                        walk_step = 1'b1;
                    end
                end
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q      <= INIT;
            flush_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (flush_done) begin
                flush_pend_q <= 1'b0;
            end else if (flush) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    // the missing address holds while the fill is in progress
    always_ff @(posedge CLK) begin
        if (state_q == READY) begin
            miss_q <= req_f;
        end
    end

endmodule

// File: logic/l1_dcache.sv
/*
 * L1 data cache top
 * two-way write-back cache between one core and memory
 */
`timescale 1ns/1ps

module l1_dcache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     flush,
    input  cache_bus_pkg::core_req_t core_req,
    output cache_bus_pkg::core_rsp_t core_rsp,
    output cache_bus_pkg::mem_req_t  mem_req,
    input  cache_bus_pkg::mem_rsp_t  mem_rsp,
    output logic                     flush_done,
    output logic                     cache_miss
);
    import cache_geom_pkg::*;

    set_idx_t                 sel_set, walk_set;
    way_t                     hit_way, victim_way, walk_way;
    line_write_t              wr;
    line_meta_t [N_WAYS-1:0]  meta;
    line_data_t [N_WAYS-1:0]  data;
    tag_t                     req_tag;
    logic                     hit, touch;
    logic                     walk_start, walk_step, walk_done;

    // core address is held stable for the whole access
    assign req_tag = core_req.addr[31 -: TAG_BITS];

    dcache_controller i_controller (
        .CLK, .nRST, .core_req, .core_rsp, .mem_req, .mem_rsp, .flush,
        .hit, .hit_way, .victim_way, .meta, .data,
        .walk_set, .walk_way, .walk_done,
        .sel_set, .wr, .touch, .walk_start, .walk_step,
        .flush_done, .cache_miss
    );

    way_lookup i_lookup (
        .CLK, .nRST, .set(sel_set), .tag(req_tag), .meta, .touch,
        .hit, .hit_way, .victim_way
    );

    flush_walker i_walker (
        .CLK, .nRST, .start(walk_start), .step(walk_step),
        .set(walk_set), .way(walk_way), .done(walk_done)
    );

    cache_line_store i_store (
        .CLK, .nRST, .sel_set, .wr, .meta, .data
    );

endmodule

// File: test/dcache_checker.sv
/*
 * response checker for the L1 data cache
 * compares each completed core access with its expected values and
 * counts miss pulses and uncached memory beats per access
 */
`timescale 1ns/1ps

module dcache_checker (
    input  logic                     CLK,
    input  logic                     nRST,
    input  cache_bus_pkg::core_req_t core_req,
    input  cache_bus_pkg::core_rsp_t core_rsp,
    input  cache_bus_pkg::mem_req_t  mem_req,
    input  cache_bus_pkg::mem_rsp_t  mem_rsp,
    input  logic                     cache_miss,
    input  cache_bus_pkg::word_t     exp_rdata,
    input  logic                     exp_miss,
    output int                       err_count,
    output int                       check_count
);
    import cache_geom_pkg::*;

    int miss_pulses;
    int nc_beats;

    task automatic check_access();
        logic uncached;
        int   exp_pulses;
        int   exp_beats;
        uncached   = core_req.addr >= NONCACHE_START;
        exp_pulses = exp_miss ? 1 : 0;
        // every uncached access must reach memory exactly once
        exp_beats  = uncached ? 1 : 0;
        check_count++;
        if (core_req.ren && core_rsp.rdata !== exp_rdata) begin
            $display("** Error: core_rsp.rdata at %h: got %h, expected %h",
                     core_req.addr, core_rsp.rdata, exp_rdata);
            err_count++;
        end
        if (miss_pulses != exp_pulses) begin
            $display("** Error: cache_miss pulses at %h: got %h, expected %h",
                     core_req.addr, miss_pulses, exp_pulses);
            err_count++;
        end
        if (nc_beats != exp_beats) begin
            $display("** Error: mem_req uncached beats at %h: got %h, expected %h",
                     core_req.addr, nc_beats, exp_beats);
            err_count++;
        end
        miss_pulses = 0;
        nc_beats    = 0;
    endtask

    // mid-cycle sampling, inputs only move just after the rising edge
    initial begin
        err_count   = 0;
        check_count = 0;
        miss_pulses = 0;
        nc_beats    = 0;
        forever begin
            @(negedge CLK);
            if (nRST) begin
                if (cache_miss) begin
                    miss_pulses++;
                end
                if ((mem_req.ren || mem_req.wen) && !mem_rsp.dwait
                        && mem_req.addr >= NONCACHE_START) begin
                    nc_beats++;
                end
                if (!core_rsp.busy && (core_req.ren || core_req.wen)) begin
                    check_access();
                end
            end
        end
    end

endmodule

// File: test/tb_l1_dcache.sv
/*
 * testbench for the L1 data cache
 * runs the operations of the stimulus file against a word memory
 * model with random wait states
 */
`timescale 1ns/1ps

module tb_l1_dcache;
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam string      STIM_FILE = "test/dcache_stimulus.txt";
    localparam logic [3:0] OP_READ   = 4'h0;
    localparam logic [3:0] OP_WRITE  = 4'h1;
    localparam logic [3:0] OP_FLUSH  = 4'hf;

    typedef struct packed {
        logic [3:0] op;
        addr_t      addr;
        byte_en_t   be;
        word_t      wdata;
        word_t      rdata;
        logic       miss;
    } stim_t;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        flush;
    core_req_t   core_req;
    core_rsp_t   core_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic        flush_done;
    logic        cache_miss;
    word_t       exp_rdata;
    logic        exp_miss;
    int          err_count;
    int          check_count;
    stim_t       stim_q[$];
    int          n_access = 0;
    logic        loaded = 1'b0;
    logic [31:0] lcg_state = 32'h4704_2ca8;
    word_t       mem_words [addr_t];

    always #4 CLK = ~CLK;

    l1_dcache i_l1_dcache (
        .CLK, .nRST, .flush, .core_req, .core_rsp, .mem_req, .mem_rsp,
        .flush_done, .cache_miss
    );

    dcache_checker i_dcache_checker (
        .CLK, .nRST, .core_req, .core_rsp, .mem_req, .mem_rsp, .cache_miss,
        .exp_rdata, .exp_miss, .err_count, .check_count
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // words never written read back as their address with a fixed xor
    function automatic word_t mem_read(addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (mem_words.exists(wa)) begin
            return mem_words[wa];
        end
        return wa ^ 32'h5A5A_0000;
    endfunction

    function automatic void mem_write(addr_t a, word_t d, byte_en_t be);
        word_t w;
        w = mem_read(a);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        mem_words[{a[31:2], 2'b00}] = w;
    endfunction

    function automatic mem_block_t read_block(addr_t a);
        mem_block_t b;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            b[k] = mem_read(a + addr_t'(4 * k));
        end
        return b;
    endfunction

    // uncached beats carry one word in slot 0
    function automatic void store_beat(mem_req_t r);
        if (r.addr >= NONCACHE_START) begin
            mem_write(r.addr, r.wdata[0], r.byte_en);
        end else begin
            for (int k = 0; k < BLOCK_WORDS; k++) begin
                mem_write(r.addr + addr_t'(4 * k), r.wdata[k], r.byte_en);
            end
        end
    endfunction

    task automatic run_access(stim_t s);
        core_req.ren     = (s.op == OP_READ);
        core_req.wen     = (s.op == OP_WRITE);
        core_req.addr    = s.addr;
        core_req.byte_en = s.be;
        core_req.wdata   = s.wdata;
        exp_rdata        = s.rdata;
        exp_miss         = s.miss;
        @(negedge CLK);
        while (core_rsp.busy) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic run_flush();
        core_req = '0;
        flush    = 1'b1;
        @(negedge CLK);
        while (!flush_done) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        flush = 1'b0;
    endtask

    // memory: wait of 1 to 4 cycles per beat, then data with wait low
    initial begin : memory_model
        mem_req_t req;
        logic     pending;
        logic     drop_wait;
        int       wait_left;
        pending   = 1'b0;
        wait_left = 0;
        mem_rsp   = '{dwait: 1'b1, rdata: '0};
        forever begin
            @(negedge CLK);
            req       = mem_req;
            drop_wait = 1'b0;
            if (req.ren || req.wen) begin
                if (!mem_rsp.dwait) begin
                    if (req.wen) begin
                        store_beat(req);
                    end
                    pending = 1'b0;
                end else begin
                    if (!pending) begin
                        pending   = 1'b1;
                        wait_left = int'(lcg_next() >> 30);
                    end
                    if (wait_left == 0) begin
                        drop_wait = 1'b1;
                    end else begin
                        wait_left--;
                    end
                end
            end
            @(posedge CLK);
            #1;
            mem_rsp.dwait = !drop_wait;
            mem_rsp.rdata = drop_wait ? read_block(req.addr) : '0;
        end
    end

    initial begin : driver
        int         fd;
        int         n;
        string      line;
        logic [3:0] op;
        addr_t      addr;
        byte_en_t   be;
        word_t      wdata;
        word_t      rdata;
        logic [3:0] miss_col;
        stim_t      s;
        nRST      = 1'b0;
        flush     = 1'b0;
        core_req  = '0;
        exp_rdata = '0;
        exp_miss  = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h", op, addr, be, wdata, rdata, miss_col);
                if (n == 6) begin
                    s = '{op, addr, be, wdata, rdata, miss_col[0]};
                    stim_q.push_back(s);
                    if (op != OP_FLUSH) begin
                        n_access++;
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (8) @(posedge CLK);
            #1;
            nRST = 1'b1;
            foreach (stim_q[i]) begin
                if (stim_q[i].op == OP_FLUSH) begin
                    run_flush();
                end else begin
                    run_access(stim_q[i]);
                end
            end
            core_req = '0;
            repeat (4) @(posedge CLK);
            if (check_count != n_access) begin
                $display("only %0d of %0d accesses were checked", check_count, n_access);
            end
            $display("accesses %0d, checks %0d, errors %0d", n_access, check_count, err_count);
            if (err_count == 0 && check_count == n_access) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = stim_q.size() * 200 + 2000;
        repeat (limit) @(posedge CLK);
        $display("timeout after %0d cycles, the cache stopped responding", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: build.f
logic/cache_geom_pkg.sv
logic/cache_bus_pkg.sv
logic/cache_line_store.sv
logic/way_lookup.sv
logic/flush_walker.sv
logic/dcache_controller.sv
logic/l1_dcache.sv
test/dcache_checker.sv
test/tb_l1_dcache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_l1_dcache
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = NO ERRORS

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^$(PASS_MSG)$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/dcache_stimulus.txt
# columns in hex: op addr byte_en wdata expected_rdata expected_miss
# op 0 is a read, 1 a write, f a flush; columns an op does not use are 0
0 00000100 f 00000000 5a5a0100 1
0 00000104 f 00000000 5a5a0104 0
1 00000100 1 11223344 00000000 0
1 00000100 c aabbccdd 00000000 0
0 00000100 f 00000000 aabb0144 0
1 00000104 5 600df00d 00000000 0
0 00000104 f 00000000 600df00d 0
1 00000104 2 00007700 00000000 0
0 00000104 f 00000000 600d770d 0
1 00000300 f cafe0300 00000000 1
0 00000500 f 00000000 5a5a0500 1
0 00000104 f 00000000 600d770d 1
0 00000100 f 00000000 aabb0144 0
1 00002000 f 12345678 00000000 1
1 00000300 3 0000beef 00000000 1
f 00000000 0 00000000 00000000 0
0 00002000 f 00000000 12345678 1
0 00000300 f 00000000 cafebeef 1
0 00000104 f 00000000 600d770d 1
0 00000100 f 00000000 aabb0144 0
1 80000010 f deadbeef 00000000 0
0 80000010 f 00000000 deadbeef 0
1 80000010 4 00550000 00000000 0
0 80000010 f 00000000 de55beef 0
0 80000020 f 00000000 da5a0020 0
1 00001238 8 9c000000 00000000 1
0 00001238 f 00000000 9c5a1238 0
1 0000123c 3 0000abcd 00000000 0
0 0000123c f 00000000 5a5aabcd 0
f 00000000 0 00000000 00000000 0
0 0000123c f 00000000 5a5aabcd 1
0 00001238 f 00000000 9c5a1238 0
